//--- verilog/l1i_pkg.sv
package l1i_pkg;

   localparam int addr_width     = 32;
   localparam int lg_line_bytes  = 4;
   localparam int words_per_line = 4;

   typedef logic [addr_width-1:0] addr_t;    // byte address or pc
   typedef logic [31:0]           word_t;
   typedef logic [(8 << lg_line_bytes)-1:0] line_t;
   typedef logic [63:0]           count_t;

   // only the classes that fetch acts on, the rest is lumped together
   typedef enum logic [1:0] {
      not_cflow,
      is_jump,          // j, jal
      is_br,            // beq $0, $0 which is always taken
      is_other_cflow    // conditional branches and register jumps
   } jump_t;

   typedef logic [(2*words_per_line)-1:0] jump_line_t;

   typedef enum logic [2:0] {
      flush_cache,
      idle,
      active,
      inject_reload,
      reload_turnaround,
      wait_for_not_full
   } fetch_state_t;

   function automatic jump_t predecode(word_t insn);
      jump_t j;
      j = not_cflow;
      case (insn[31:26])
         6'd0: j = (insn[5:1] == 5'd4) ? is_other_cflow : not_cflow;   // jr, jalr
         6'd1: j = is_other_cflow;                                     // regimm
         6'd2, 6'd3: j = is_jump;
         6'd4: j = (insn[25:16] == 10'd0) ? is_br : is_other_cflow;
         6'd5, 6'd6, 6'd7: j = is_other_cflow;
         6'd17: j = (insn[25:21] == 5'd8) ? is_other_cflow : not_cflow; // bc1x
         6'd20, 6'd21, 6'd22, 6'd23: j = is_other_cflow;              // branch likely
         default: j = not_cflow;
      endcase
      return j;
   endfunction

endpackage

//--- verilog/l1i_lookup_if.sv
`timescale 1ns/1ns

interface l1i_lookup_if;
   import l1i_pkg::*;

   logic  lookup_req;
   addr_t lookup_pc;
   logic  flush_start;   // one cycle, starts the invalidate walk
   addr_t fill_addr;     // line of the outstanding refill

   // valid one cycle after lookup_req
   addr_t rsp_pc;
   logic  rsp_hit;
   logic  rsp_miss;
   word_t rsp_word;
   jump_t rsp_jump;
   logic  flush_done;

   modport ctrl (
      output lookup_req,
      output lookup_pc,
      output flush_start,
      output fill_addr,
      input  rsp_pc,
      input  rsp_hit,
      input  rsp_miss,
      input  rsp_word,
      input  rsp_jump,
      input  flush_done
   );

   modport arrays (
      input  lookup_req,
      input  lookup_pc,
      input  flush_start,
      input  fill_addr,
      output rsp_pc,
      output rsp_hit,
      output rsp_miss,
      output rsp_word,
      output rsp_jump,
      output flush_done
   );

endinterface

//--- verilog/l1i_push_if.sv
`timescale 1ns/1ns

interface l1i_push_if;
   import l1i_pkg::*;

   logic  push;
   addr_t pc;
   word_t data;
   logic  pred;          // entry redirected fetch
   addr_t pred_target;
   logic  clear;         // wins over push
   logic  full;

   modport ctrl (
      output push,
      output pc,
      output data,
      output pred,
      output pred_target,
      output clear,
      input  full
   );

   modport queue (
      input  push,
      input  pc,
      input  data,
      input  pred,
      input  pred_target,
      input  clear,
      output full
   );

endinterface

//--- verilog/l1i_arrays.sv
`timescale 1ns/1ns

module l1i_arrays #(
   parameter int lg_num_sets = 4
) (
   input  logic            clk,
   input  logic            reset,
   l1i_lookup_if.arrays    lk,
   input  logic            mem_rsp_valid,
   input  l1i_pkg::line_t  mem_rsp_load_data,
   output l1i_pkg::count_t cache_accesses,
   output l1i_pkg::count_t cache_hits
);
   import l1i_pkg::*;

   localparam int num_sets = 1 << lg_num_sets;
   localparam int idx_lo   = lg_line_bytes;
   localparam int idx_hi   = lg_line_bytes + lg_num_sets;
   localparam int tag_bits = addr_width - idx_hi;
   localparam int lg_words = lg_line_bytes - 2;
   localparam int wbits    = $bits(word_t);
   localparam int jbits    = $bits(jump_t);

   typedef logic [lg_num_sets-1:0] set_t;
   typedef logic [tag_bits-1:0]    tag_t;

   logic [num_sets-1:0] r_valid;
   tag_t       tag_mem  [num_sets];
   line_t      data_mem [num_sets];
   jump_line_t pd_mem   [num_sets];

   set_t       t_rd_set, t_fill_set, t_walk_set, r_walk_set;
   logic       t_walk_active, r_walking, r_flush_done;
   logic       r_req, r_valid_out, t_hit;
   addr_t      r_pc;
   tag_t       r_tag_out;
   line_t      r_line_out, t_fill_line;
   jump_line_t r_pd_out, t_fill_pd;
   logic [lg_words-1:0] t_word_idx;
   count_t     r_accesses, r_hits;

   assign t_rd_set   = lk.lookup_pc[idx_hi-1:idx_lo];
   assign t_fill_set = lk.fill_addr[idx_hi-1:idx_lo];

   // memory words arrive little endian, swap bytes and predecode on the way in
   for (genvar w = 0; w < words_per_line; w++)
   begin : g_fill
      word_t raw;
      assign raw = mem_rsp_load_data[w*wbits +: wbits];
      assign t_fill_line[w*wbits +: wbits] = {raw[7:0], raw[15:8], raw[23:16], raw[31:24]};
      assign t_fill_pd[w*jbits +: jbits] = predecode(t_fill_line[w*wbits +: wbits]);
   end

   // invalidate walk, set 0 goes in the same cycle as flush_start
   assign t_walk_active = lk.flush_start || r_walking;
   assign t_walk_set    = lk.flush_start ? '0 : r_walk_set;

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         r_walking    <= 1'b0;
         r_walk_set   <= '0;
         r_flush_done <= 1'b0;
         r_valid      <= '0;
         r_valid_out  <= 1'b0;
         r_req        <= 1'b0;
      end
      else
      begin
         r_flush_done <= t_walk_active && (t_walk_set == set_t'(num_sets-1));
         r_walking    <= t_walk_active && (t_walk_set != set_t'(num_sets-1));
         r_walk_set   <= t_walk_active ? t_walk_set + 1'b1 : '0;
         if (t_walk_active)
            r_valid[t_walk_set] <= 1'b0;
         else if (mem_rsp_valid)
            r_valid[t_fill_set] <= 1'b1;
         r_valid_out <= r_valid[t_rd_set];
         r_req       <= lk.lookup_req;
      end
   end

   always_ff @(posedge clk)
   begin
      if (mem_rsp_valid)
      begin
         tag_mem[t_fill_set]  <= lk.fill_addr[addr_width-1:idx_hi];
         data_mem[t_fill_set] <= t_fill_line;
         pd_mem[t_fill_set]   <= t_fill_pd;
      end
      r_tag_out  <= tag_mem[t_rd_set];
      r_line_out <= data_mem[t_rd_set];
      r_pd_out   <= pd_mem[t_rd_set];
      r_pc       <= lk.lookup_pc;
   end

   assign t_word_idx = r_pc[idx_lo-1:2];
   assign t_hit      = r_valid_out && (r_tag_out == r_pc[addr_width-1:idx_hi]);

   assign lk.rsp_pc     = r_pc;
   assign lk.rsp_hit    = r_req && t_hit;
   assign lk.rsp_miss   = r_req && !t_hit;
   assign lk.rsp_word   = r_line_out[t_word_idx*wbits +: wbits];
   assign lk.rsp_jump   = jump_t'(r_pd_out[t_word_idx*jbits +: jbits]);
   assign lk.flush_done = r_flush_done;

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         r_accesses <= '0;
         r_hits     <= '0;
      end
      else
      begin
         if (r_req)
            r_accesses <= r_accesses + 1'b1;
         if (r_req && t_hit)
            r_hits <= r_hits + 1'b1;
      end
   end

   assign cache_accesses = r_accesses;
   assign cache_hits     = r_hits;

endmodule

//--- verilog/fetch_ctrl.sv
`timescale 1ns/1ns

module fetch_ctrl #(
   parameter int lg_num_sets = 4
) (
   input  logic           clk,
   input  logic           reset,
   l1i_lookup_if.ctrl     lk,
   l1i_push_if.ctrl       fq,
   input  logic           flush_req,
   output logic           flush_complete,
   input  l1i_pkg::addr_t restart_pc,
   input  logic           restart_valid,
   output logic           restart_ack,
   output logic           mem_req_valid,
   output l1i_pkg::addr_t mem_req_addr,
   input  logic           mem_rsp_valid
);
   import l1i_pkg::*;

   localparam int idx_lo = lg_line_bytes;
   localparam int idx_hi = lg_line_bytes + lg_num_sets;

   fetch_state_t r_state, n_state;
   addr_t r_pc, n_pc;              // next pc to look up
   addr_t r_miss_pc, n_miss_pc;    // pc to re-look up after refill or stall
   addr_t r_restart_pc, n_restart_pc;
   addr_t r_mem_req_addr, n_mem_req_addr;
   logic  r_mem_req_valid, n_mem_req_valid;
   logic  r_restart_req, n_restart_req;
   logic  r_flush_req, n_flush_req;
   logic  r_delay_slot, n_delay_slot;
   logic  r_restart_ack, n_restart_ack;
   logic  r_flush_complete, n_flush_complete;
   logic  r_flush_start, n_flush_start;
   logic  t_steerable, t_req, t_clear, t_push, t_take;
   addr_t t_lookup_pc, t_target, t_simm;

   assign n_restart_pc = restart_valid ? restart_pc : r_restart_pc;
   assign t_steerable  = (r_state != flush_cache) && (r_state != inject_reload);

   always_comb
   begin
      t_simm = {{(addr_width-16){lk.rsp_word[15]}}, lk.rsp_word[15:0]};
      if (lk.rsp_jump == is_jump)
         t_target = {lk.rsp_pc[addr_width-1:28], lk.rsp_word[25:0], 2'b00};
      else
         t_target = lk.rsp_pc + addr_t'(4) + {t_simm[addr_width-3:0], 2'b00};
   end

   always_comb
   begin
      n_state          = r_state;
      n_pc             = r_pc;
      n_miss_pc        = r_miss_pc;
      n_mem_req_addr   = r_mem_req_addr;
      n_mem_req_valid  = 1'b0;
      n_restart_req    = r_restart_req | restart_valid;
      n_flush_req      = r_flush_req | flush_req;
      n_delay_slot     = r_delay_slot;
      n_restart_ack    = 1'b0;
      n_flush_complete = 1'b0;
      n_flush_start    = 1'b0;
      t_req            = 1'b0;
      t_lookup_pc      = r_pc;
      t_clear          = 1'b0;
      t_push           = 1'b0;
      t_take           = 1'b0;

      if (t_steerable && n_flush_req)       // flush beats restart
      begin
         n_flush_req   = 1'b0;
         n_flush_start = 1'b1;
         n_delay_slot  = 1'b0;
         t_clear       = 1'b1;
         n_state       = flush_cache;
      end
      else if (t_steerable && n_restart_req)
      begin
         n_restart_req = 1'b0;
         n_restart_ack = 1'b1;
         n_pc          = n_restart_pc;
         n_delay_slot  = 1'b0;
         t_clear       = 1'b1;
         n_state       = active;
      end
      else
      begin
         case (r_state)
            flush_cache:
            begin
               if (lk.flush_done)
               begin
                  n_flush_complete = 1'b1;
                  n_state          = idle;
               end
            end
            active:
            begin
               t_req = 1'b1;
               n_pc  = r_pc + addr_t'(4);
               if (lk.rsp_miss)
               begin
                  t_req           = 1'b0;
                  n_pc            = r_pc;
                  n_miss_pc       = lk.rsp_pc;
                  n_mem_req_valid = 1'b1;
                  // tag and set of the missing line
                  n_mem_req_addr  = {lk.rsp_pc[addr_width-1:idx_hi],
                                     lk.rsp_pc[idx_hi-1:idx_lo], {idx_lo{1'b0}}};
                  n_state         = inject_reload;
               end
               else if (lk.rsp_hit && fq.full)
               begin
                  t_req     = 1'b0;
                  n_pc      = r_pc;
                  n_miss_pc = lk.rsp_pc;
                  n_state   = wait_for_not_full;
               end
               else if (lk.rsp_hit)
               begin
                  t_push = 1'b1;
                  if (r_delay_slot)
                     n_delay_slot = 1'b0;   // slot itself never redirects
                  else if (lk.rsp_jump == is_jump || lk.rsp_jump == is_br)
                  begin
                     t_take       = 1'b1;
                     n_delay_slot = 1'b1;   // slot lookup is already in flight
                     n_pc         = t_target;
                  end
               end
            end
            inject_reload:
            begin
               if (mem_rsp_valid)
                  n_state = reload_turnaround;
            end
            reload_turnaround, wait_for_not_full:
            begin
               if (!fq.full)
               begin
                  t_req       = 1'b1;
                  t_lookup_pc = r_miss_pc;
                  n_state     = active;
               end
            end
            default:
            begin
            end
         endcase
      end
   end

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         r_state          <= flush_cache;
         r_pc             <= '0;
         r_miss_pc        <= '0;
         r_mem_req_addr   <= '0;
         r_mem_req_valid  <= 1'b0;
         r_restart_req    <= 1'b0;
         r_flush_req      <= 1'b0;
         r_delay_slot     <= 1'b0;
         r_restart_ack    <= 1'b0;
         r_flush_complete <= 1'b0;
         r_flush_start    <= 1'b1;   // walk starts right out of reset
      end
      else
      begin
         r_state          <= n_state;
         r_pc             <= n_pc;
         r_miss_pc        <= n_miss_pc;
         r_mem_req_addr   <= n_mem_req_addr;
         r_mem_req_valid  <= n_mem_req_valid;
         r_restart_req    <= n_restart_req;
         r_flush_req      <= n_flush_req;
         r_delay_slot     <= n_delay_slot;
         r_restart_ack    <= n_restart_ack;
         r_flush_complete <= n_flush_complete;
         r_flush_start    <= n_flush_start;
      end
   end

   always_ff @(posedge clk)
   begin
      r_restart_pc <= n_restart_pc;
   end

   assign lk.lookup_req  = t_req;
   assign lk.lookup_pc   = t_lookup_pc;
   assign lk.flush_start = r_flush_start;
   assign lk.fill_addr   = r_mem_req_addr;

   assign fq.push        = t_push;
   assign fq.pc          = lk.rsp_pc;
   assign fq.data        = lk.rsp_word;
   assign fq.pred        = t_take;
   assign fq.pred_target = t_take ? t_target : '0;
   assign fq.clear       = t_clear;

   assign flush_complete = r_flush_complete;
   assign restart_ack    = r_restart_ack;
   assign mem_req_valid  = r_mem_req_valid;
   assign mem_req_addr   = r_mem_req_addr;

endmodule

//--- verilog/fetch_queue.sv
`timescale 1ns/1ns

module fetch_queue #(
   parameter int lg_fq_entries = 3
) (
   input  logic           clk,
   input  logic           reset,
   l1i_push_if.queue      fq,
   output l1i_pkg::addr_t insn_pc,
   output l1i_pkg::word_t insn_data,
   output logic           insn_pred,
   output l1i_pkg::addr_t insn_pred_target,
   output logic           insn_valid,
   input  logic           insn_ack
);
   import l1i_pkg::*;

   localparam int fq_entries = 1 << lg_fq_entries;

   typedef logic [lg_fq_entries:0] ptr_t;   // extra wrap bit

   addr_t pc_mem     [fq_entries];
   word_t data_mem   [fq_entries];
   logic  pred_mem   [fq_entries];
   addr_t target_mem [fq_entries];

   ptr_t r_head, r_tail;
   logic t_empty;

   assign t_empty = (r_head == r_tail);
   assign fq.full = (r_head[lg_fq_entries] != r_tail[lg_fq_entries]) &&
                    (r_head[lg_fq_entries-1:0] == r_tail[lg_fq_entries-1:0]);

   always_ff @(posedge clk)
   begin
      if (fq.push)
      begin
         pc_mem[r_tail[lg_fq_entries-1:0]]     <= fq.pc;
         data_mem[r_tail[lg_fq_entries-1:0]]   <= fq.data;
         pred_mem[r_tail[lg_fq_entries-1:0]]   <= fq.pred;
         target_mem[r_tail[lg_fq_entries-1:0]] <= fq.pred_target;
      end
   end

   always_ff @(posedge clk)
   begin
      if (reset || fq.clear)
      begin
         r_head <= '0;
         r_tail <= '0;
      end
      else
      begin
         if (fq.push)
            r_tail <= r_tail + 1'b1;
         if (insn_ack && !t_empty)
            r_head <= r_head + 1'b1;
      end
   end

   // head entry straight to the outputs
   assign insn_valid       = !t_empty;
   assign insn_pc          = pc_mem[r_head[lg_fq_entries-1:0]];
   assign insn_data        = data_mem[r_head[lg_fq_entries-1:0]];
   assign insn_pred        = pred_mem[r_head[lg_fq_entries-1:0]];
   assign insn_pred_target = target_mem[r_head[lg_fq_entries-1:0]];

endmodule

//--- verilog/l1i_top.sv
`timescale 1ns/1ns

module l1i_top #(
   parameter int lg_num_sets   = 4,
   parameter int lg_fq_entries = 3
) (
   input  logic            clk,
   input  logic            reset,
   input  logic            flush_req,
   output logic            flush_complete,
   input  l1i_pkg::addr_t  restart_pc,
   input  logic            restart_valid,
   output logic            restart_ack,
   output l1i_pkg::addr_t  insn_pc,
   output l1i_pkg::word_t  insn_data,
   output logic            insn_pred,
   output l1i_pkg::addr_t  insn_pred_target,
   output logic            insn_valid,
   input  logic            insn_ack,
   output logic            mem_req_valid,
   output l1i_pkg::addr_t  mem_req_addr,
   input  logic            mem_rsp_valid,
   input  l1i_pkg::line_t  mem_rsp_load_data,
   output l1i_pkg::count_t cache_accesses,
   output l1i_pkg::count_t cache_hits
);

   l1i_lookup_if i_lookup_if ();
   l1i_push_if   i_push_if ();

   l1i_arrays #(.lg_num_sets(lg_num_sets)) i_arrays (
      .clk               (clk),
      .reset             (reset),
      .lk                (i_lookup_if.arrays),
      .mem_rsp_valid     (mem_rsp_valid),
      .mem_rsp_load_data (mem_rsp_load_data),
      .cache_accesses    (cache_accesses),
      .cache_hits        (cache_hits)
   );

   fetch_ctrl #(.lg_num_sets(lg_num_sets)) i_ctrl (
      .clk            (clk),
      .reset          (reset),
      .lk             (i_lookup_if.ctrl),
      .fq             (i_push_if.ctrl),
      .flush_req      (flush_req),
      .flush_complete (flush_complete),
      .restart_pc     (restart_pc),
      .restart_valid  (restart_valid),
      .restart_ack    (restart_ack),
      .mem_req_valid  (mem_req_valid),
      .mem_req_addr   (mem_req_addr),
      .mem_rsp_valid  (mem_rsp_valid)
   );

   fetch_queue #(.lg_fq_entries(lg_fq_entries)) i_queue (
      .clk              (clk),
      .reset            (reset),
      .fq               (i_push_if.queue),
      .insn_pc          (insn_pc),
      .insn_data        (insn_data),
      .insn_pred        (insn_pred),
      .insn_pred_target (insn_pred_target),
      .insn_valid       (insn_valid),
      .insn_ack         (insn_ack)
   );

endmodule

//--- tests/l1i_assert.sv
`timescale 1ns/1ns

module l1i_assert (
   input logic clk,
   input logic reset,
   input logic flush_complete,
   input logic restart_ack,
   input logic insn_valid,
   input logic mem_req_valid
);

   int failures = 0;

   // queue is empty while the restart is acknowledged
   assert property (@(posedge clk) disable iff (reset) restart_ack |-> !insn_valid)
   else
   begin
      $error("insn_valid high during restart_ack");
      failures++;
   end

   // queue was cleared when the flush began and nothing was pushed since
   assert property (@(posedge clk) disable iff (reset) flush_complete |-> !insn_valid)
   else
   begin
      $error("insn_valid high during flush_complete");
      failures++;
   end

   assert property (@(posedge clk) disable iff (reset) mem_req_valid |=> !mem_req_valid)
   else
   begin
      $error("mem_req_valid longer than one cycle");
      failures++;
   end

   assert property (@(posedge clk) disable iff (reset) restart_ack |=> !restart_ack)
   else
   begin
      $error("restart_ack longer than one cycle");
      failures++;
   end

   assert property (@(posedge clk) disable iff (reset) flush_complete |=> !flush_complete)
   else
   begin
      $error("flush_complete longer than one cycle");
      failures++;
   end

endmodule

//--- tests/l1i_checker.sv
`timescale 1ns/1ns

module l1i_checker (
   input  logic            clk,
   input  logic            reset,
   input  logic            flush_complete,
   input  logic            restart_ack,
   input  logic            insn_valid,
   input  logic            insn_ack,
   input  l1i_pkg::addr_t  insn_pc,
   input  l1i_pkg::word_t  insn_data,
   input  logic            insn_pred,
   input  l1i_pkg::addr_t  insn_pred_target,
   input  logic            mem_req_valid,
   input  l1i_pkg::addr_t  mem_req_addr,
   input  logic            mem_rsp_valid,
   input  l1i_pkg::line_t  mem_rsp_load_data,
   input  l1i_pkg::count_t cache_accesses,
   input  l1i_pkg::count_t cache_hits,
   output int              errors
);
   import l1i_pkg::*;

   addr_t  q_pc [$];
   word_t  q_data [$];
   logic   q_pred [$];
   addr_t  q_target [$];
   word_t  fetched [addr_t];     // memory words seen on refills
   bit     requested [addr_t];   // lines asked for in this test
   addr_t  last_req;
   count_t hits_at_start;
   int     test_num, test_mode, delivered, mem_reqs, flush_pulses, restart_acks;
   int     tests_ok, tests_bad, errors_at_start;
   bit     started, after_flush;

   initial
   begin
      errors = 0;
      flush_pulses = 0;
      tests_ok = 0;
      tests_bad = 0;
      started = 0;
      after_flush = 0;
   end

   function automatic word_t swap_bytes(word_t w);
      return {w[7:0], w[15:8], w[23:16], w[31:24]};
   endfunction

   task automatic report_value(string name, logic [63:0] got, logic [63:0] exp);
      $display("[FAIL] %s: got %h expected %h", name, got, exp);
      errors++;
   endtask

   task automatic report_text(string what);
      $display("test %0d: %s", test_num, what);
      errors++;
   endtask

   task automatic expect_insn(addr_t pc, word_t data, logic pred, addr_t target);
      q_pc.push_back(pc);
      q_data.push_back(data);
      q_pred.push_back(pred);
      q_target.push_back(target);
   endtask

   task automatic start_test(int num, int mode);
      test_num = num;
      test_mode = mode;
      if (!started && flush_pulses != 1)
         report_text($sformatf("%0d flush_complete pulses after reset, not one", flush_pulses));
      started = 1;
      after_flush = 0;
      delivered = 0;
      mem_reqs = 0;
      restart_acks = 0;
      requested.delete();
      hits_at_start = cache_hits;
      errors_at_start = errors;
   endtask

   task automatic finish_test();
      if (q_pc.size() != 0)
         report_text($sformatf("%0d expected instructions never delivered", q_pc.size()));
      if (restart_acks != 1)
         report_text($sformatf("%0d restart_ack pulses, not one", restart_acks));
      if (test_mode == 1 && mem_reqs != 0)
         report_text("memory requests on a warm restart");
      if (test_mode == 3 && mem_reqs == 0)
         report_text("no memory requests after the flush");
      if (cache_hits - hits_at_start < count_t'(delivered))
         report_value("cache_hits delta", cache_hits - hits_at_start, delivered);
      if (cache_accesses < cache_hits)
         report_value("cache_accesses", cache_accesses, cache_hits);
      if (errors == errors_at_start)
         tests_ok++;
      else
         tests_bad++;
      $display("test %0d %s: %0d delivered, %0d memory requests", test_num,
               (errors == errors_at_start) ? "ok" : "bad", delivered, mem_reqs);
   endtask

   task automatic print_summary();
      $display("summary: %0d tests, %0d ok, %0d bad, %0d errors",
               tests_ok + tests_bad, tests_ok, tests_bad, errors);
   endtask

   task automatic compare_head();
      if (q_pc.size() == 0)
         report_text($sformatf("instruction at %h delivered beyond the stream", insn_pc));
      else
      begin
         if (insn_pc != q_pc[0])
            report_value("insn_pc", insn_pc, q_pc[0]);
         if (insn_data != q_data[0])
            report_value("insn_data", insn_data, q_data[0]);
         if (insn_pred != q_pred[0])
            report_value("insn_pred", insn_pred, q_pred[0]);
         if (insn_pred_target != q_target[0])
            report_value("insn_pred_target", insn_pred_target, q_target[0]);
         if (!fetched.exists(insn_pc))
            report_text($sformatf("no refill seen for pc %h", insn_pc));
         else if (insn_data != swap_bytes(fetched[insn_pc]))
            report_value("insn_data vs memory", insn_data, swap_bytes(fetched[insn_pc]));
         void'(q_pc.pop_front());
         void'(q_data.pop_front());
         void'(q_pred.pop_front());
         void'(q_target.pop_front());
      end
      delivered++;
   endtask

   always @(posedge clk)
   begin
      if (!reset)
      begin
         if (flush_complete)
         begin
            flush_pulses++;
            after_flush = started;
         end
         if (restart_ack)
            restart_acks++;
         if (insn_valid && !started)
            report_text("insn_valid before the first restart");
         if (insn_valid && after_flush)
            report_text("instruction delivered after flush");
         if (mem_req_valid)
         begin
            mem_reqs++;
            if (mem_req_addr[3:0] != 4'h0)
               report_value("mem_req_addr", mem_req_addr, {mem_req_addr[31:4], 4'h0});
            if (requested.exists(mem_req_addr))
               report_text($sformatf("line %h requested twice", mem_req_addr));
            requested[mem_req_addr] = 1;
            last_req = mem_req_addr;
         end
         if (mem_rsp_valid)
            for (int w = 0; w < 4; w++)
               fetched[last_req + 4*w] = mem_rsp_load_data[w*32 +: 32];
         if (insn_valid && insn_ack)
            compare_head();
      end
   end

endmodule

//--- tests/l1i_tb.sv
`timescale 1ns/1ns

module l1i_tb;
   import l1i_pkg::*;

   localparam int lg_num_sets  = 4;
   localparam int cycle_budget = 200;   // per test

   logic   clk, reset, flush_req, restart_valid, insn_ack, mem_rsp_valid;
   addr_t  restart_pc;
   line_t  mem_rsp_load_data;
   logic   flush_complete, restart_ack, insn_valid, insn_pred, mem_req_valid;
   addr_t  insn_pc, insn_pred_target, mem_req_addr;
   word_t  insn_data;
   count_t cache_accesses, cache_hits;
   int     errors, acked, ack_limit, limit, first;
   bit     loaded;

   word_t  mem [addr_t];
   addr_t  test_pc [$];
   int     test_mode [$];
   int     test_len [$];
   addr_t  exp_pc [$];
   word_t  exp_data [$];
   logic   exp_pred [$];
   addr_t  exp_target [$];

   l1i_top #(.lg_num_sets(lg_num_sets), .lg_fq_entries(3)) i_l1i_top (.*);
   l1i_checker i_checker (.*);
   bind l1i_top l1i_assert i_assert (.*);

   initial
   begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   // unlisted words decode as opcode 0 so stray prefetch never redirects
   function automatic word_t memory_word(addr_t a);
      word_t d;
      if (mem.exists(a))
         return mem[a];
      d = {6'd0, a[27:2] ^ {22'd0, a[31:28]}};
      return {d[7:0], d[15:8], d[23:16], d[31:24]};
   endfunction

   task automatic load_vectors();
      int fd;
      string line, tag;
      logic [31:0] v0, v1, v2, v3, v4;
      fd = $fopen("tests/l1i_vectors.txt", "r");
      while (fd != 0 && !$feof(fd))
      begin
         line = "";
         tag = "";
         void'($fgets(line, fd));
         void'($sscanf(line, "%s %h %h %h %h %h", tag, v0, v1, v2, v3, v4));
         case (tag)
            "m":
            begin
               mem[v0] = v1;
               mem[v0 + 4] = v2;
               mem[v0 + 8] = v3;
               mem[v0 + 12] = v4;
            end
            "t":
            begin
               test_pc.push_back(v0);
               test_mode.push_back(v1);
               test_len.push_back(0);
            end
            "e":
            begin
               exp_pc.push_back(v0);
               exp_data.push_back(v1);
               exp_pred.push_back(v2[0]);
               exp_target.push_back(v3);
               test_len[test_len.size()-1]++;
            end
            default:
            begin
            end
         endcase
      end
      if (fd == 0)
         $display("cannot open tests/l1i_vectors.txt");
      else
         $fclose(fd);
   endtask

   task automatic run_test(int t, int base);
      i_checker.start_test(t + 1, test_mode[t]);
      for (int i = base; i < base + test_len[t]; i++)
         i_checker.expect_insn(exp_pc[i], exp_data[i], exp_pred[i], exp_target[i]);
      @(negedge clk);
      restart_pc = test_pc[t];
      restart_valid = 1'b1;
      @(negedge clk);
      restart_valid = 1'b0;
      @(posedge clk);
      while (!restart_ack)
         @(posedge clk);
      ack_limit = acked + test_len[t];
      while (acked < ack_limit)
         @(posedge clk);
      if (test_mode[t] == 2)
      begin
         @(negedge clk);
         flush_req = 1'b1;
         @(negedge clk);
         flush_req = 1'b0;
         @(posedge clk);
         while (!flush_complete)
            @(posedge clk);
         repeat (20) @(posedge clk);
      end
      else
         repeat (40) @(posedge clk);   // let prefetch settle
      i_checker.finish_test();
   endtask

   // memory answers each request 1 to 8 cycles later
   initial
   begin
      int delay;
      addr_t line_addr;
      forever
      begin
         @(posedge clk);
         if (mem_req_valid && !reset)
         begin
            line_addr = mem_req_addr;
            delay = 1 + $urandom % 8;
            repeat (delay) @(negedge clk);
            for (int w = 0; w < 4; w++)
               mem_rsp_load_data[w*32 +: 32] = memory_word(line_addr + 4*w);
            mem_rsp_valid = 1'b1;
            @(negedge clk);
            mem_rsp_valid = 1'b0;
         end
      end
   end

   always @(negedge clk)
      insn_ack = (acked < ack_limit) && ($urandom % 2 == 1);

   always @(posedge clk)
      if (insn_valid && insn_ack)
         acked <= acked + 1;

   initial
   begin
      wait (loaded);
      repeat (limit) @(posedge clk);
      $display("timeout: run did not finish within %0d cycles", limit);
      $display("tests failed");
      $finish;
   end

   initial
   begin
      void'($urandom(96652));
      reset = 1'b1;
      flush_req = 1'b0;
      restart_valid = 1'b0;
      restart_pc = '0;
      insn_ack = 1'b0;
      mem_rsp_valid = 1'b0;
      mem_rsp_load_data = '0;
      acked = 0;
      ack_limit = 0;
      load_vectors();
      limit = test_pc.size() * cycle_budget + (1 << lg_num_sets) + 1 + 40;
      loaded = 1;
      repeat (10) @(posedge clk);
      @(negedge clk);
      reset = 1'b0;
      while (!flush_complete)
         @(posedge clk);
      repeat (5) @(negedge clk);
      first = 0;
      for (int t = 0; t < test_pc.size(); t++)
      begin
         run_test(t, first);
         first += test_len[t];
      end
      i_checker.print_summary();
      if (test_pc.size() > 0 && errors == 0 && i_l1i_top.i_assert.failures == 0)
         $display("all tests passed");
      else
         $display("tests failed");
      $finish;
   end

endmodule

//--- tests/l1i_vectors.txt
# m: line address, then its four memory words in little-endian byte order
# t: restart pc, mode (0 plain, 1 warm with no refills, 2 flush at end, 3 cold after flush)
# e: expected pc, instruction, pred, pred_target
m 100 01000124 50000008 03000324 00000000
m 110 0a000a24 0b000b24 0c000c24 fcff0010
m 120 0d000d24 00000000 00000000 00000000
m 140 6000000c 04000424 00000000 00000000
m 180 0f000010 05000524 00000000 00000000
m 1c0 06000624 00000000 00000000 00000000
t 100 0
e 100 24010001 0 0
e 104 08000050 1 140
e 108 24030003 0 0
e 140 0c000060 1 180
e 144 24040004 0 0
e 180 1000000f 1 1c0
e 184 24050005 0 0
e 1c0 24060006 0 0
t 110 0
e 110 240a000a 0 0
e 114 240b000b 0 0
e 118 240c000c 0 0
e 11c 1000fffc 1 110
e 120 240d000d 0 0
e 110 240a000a 0 0
e 114 240b000b 0 0
e 118 240c000c 0 0
e 11c 1000fffc 1 110
e 120 240d000d 0 0
t 140 1
e 140 0c000060 1 180
e 144 24040004 0 0
e 180 1000000f 1 1c0
e 184 24050005 0 0
e 1c0 24060006 0 0
t 110 2
e 110 240a000a 0 0
e 114 240b000b 0 0
t 180 3
e 180 1000000f 1 1c0
e 184 24050005 0 0
e 1c0 24060006 0 0

//--- verilog.f
verilog/l1i_pkg.sv
verilog/l1i_lookup_if.sv
verilog/l1i_push_if.sv
verilog/l1i_arrays.sv
verilog/fetch_ctrl.sv
verilog/fetch_queue.sv
verilog/l1i_top.sv
tests/l1i_assert.sv
tests/l1i_checker.sv
tests/l1i_tb.sv

//--- Bender.yml
package:
  name: l1i

sources:
  - files:
      - verilog/l1i_pkg.sv
      - verilog/l1i_lookup_if.sv
      - verilog/l1i_push_if.sv
      - verilog/l1i_arrays.sv
      - verilog/fetch_ctrl.sv
      - verilog/fetch_queue.sv
      - verilog/l1i_top.sv
  - target: test
    files:
      - tests/l1i_assert.sv
      - tests/l1i_checker.sv
      - tests/l1i_tb.sv
